/* verilog/lsu_bridge_pkg.sv */
package lsu_bridge_pkg;

    typedef logic [31:0] addr_t;  // bus address
    typedef logic [31:0] word_t;  // bus data word
    typedef logic [3:0]  strb_t;  // one bit per byte lane
    typedef logic [7:0]  byte_t;  // serial payload

    // address map
    localparam addr_t RAM_BASE       = 32'h8000_0000;  // data ram window start
    localparam addr_t UART_DATA_ADDR = 32'hBFD0_03F8;  // rx pop on read, tx start on write
    localparam addr_t UART_STAT_ADDR = 32'hBFD0_03FC;  // read only

    // status word bit positions
    localparam int STAT_TX_IDLE  = 0;  // transmitter free
    localparam int STAT_RX_AVAIL = 1;  // fifo not empty

    // target picked by the address decoder
    typedef enum logic [1:0] {
        ACC_RAM,
        ACC_UART_DATA,
        ACC_UART_STAT,
        ACC_BAD
    } access_e;

    typedef enum logic [1:0] {
        BR_IDLE,      // waiting for setup
        BR_ACCESS,    // first access cycle
        BR_RAM_WAIT,  // registered ram read in flight
        BR_TX_WAIT    // data write stalled on busy tx
    } bridge_state_e;

    // both serial engines walk the same frame
    typedef enum logic [1:0] {
        SER_IDLE,
        SER_START,
        SER_DATA,
        SER_STOP
    } serial_state_e;

endpackage

/* verilog/bus_ifs.sv */
`timescale 1ns/100ps

// word port between the bridge and the data ram
interface ram_port_if import lsu_bridge_pkg::*; #(
    parameter int AW = 8  // word index width
) ();
    logic          we;
    strb_t         be;
    logic [AW-1:0] addr;   // word index, not byte address
    word_t         wdata;
    word_t         rdata;  // word addressed one cycle earlier

    modport bridge (output we, be, addr, wdata, input rdata);
    modport mem    (input we, be, addr, wdata, output rdata);
endinterface

// uart side of the bridge, shared by tx and the rx fifo
interface uart_regs_if import lsu_bridge_pkg::*; ();
    logic  tx_start;  // single cycle, only when tx idle
    byte_t tx_data;
    logic  tx_busy;
    logic  rx_avail;
    byte_t rx_data;   // fifo head
    logic  rx_pop;    // single cycle, only when rx_avail

    modport bridge (
        output tx_start, tx_data, rx_pop,
        input  tx_busy, rx_avail, rx_data
    );
    modport tx   (input tx_start, tx_data, output tx_busy);
    modport fifo (input rx_pop, output rx_avail, rx_data);
endinterface

/* verilog/serial_rx.sv */
`timescale 1ns/100ps

module serial_rx import lsu_bridge_pkg::*; #(
    parameter int CLKS_PER_BIT = 16
) (
    input  logic  clk_i,
    input  logic  rst_i,
    input  logic  rxd_i,
    output logic  byte_valid_o,  // one cycle pulse
    output byte_t byte_o
);
    localparam int CW = $clog2(CLKS_PER_BIT);
    localparam logic [CW-1:0] FULL_BIT = CW'(CLKS_PER_BIT - 1);
    localparam logic [CW-1:0] HALF_BIT = CW'(CLKS_PER_BIT / 2 - 1);

    logic [1:0]    rx_sync;  // metastability pair
    logic          rx_prev;  // for falling edge
    logic          rx_s;
    serial_state_e state;
    logic [CW-1:0] cnt;
    logic [2:0]    bit_idx;
    byte_t         shreg;
    logic          sample;

    assign rx_s   = rx_sync[1];
    assign sample = (state == SER_DATA) && (cnt == FULL_BIT);  // mid data bit
    assign byte_o = shreg;

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            rx_sync <= 2'b11;  // line idles high
            rx_prev <= 1'b1;
        end else begin
            rx_sync <= {rx_sync[0], rxd_i};
            rx_prev <= rx_s;
        end
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            state        <= SER_IDLE;
            cnt          <= '0;
            bit_idx      <= '0;
            byte_valid_o <= 1'b0;
        end else begin
            byte_valid_o <= 1'b0;
            cnt          <= cnt + 1'b1;
            case (state)
                SER_IDLE: begin
                    cnt <= '0;
                    if (rx_prev && !rx_s) begin  // start edge
                        state <= SER_START;
                    end
                end
                SER_START: begin
                    if (cnt == HALF_BIT) begin  // middle of start bit
                        cnt     <= '0;
                        bit_idx <= '0;
                        state   <= rx_s ? SER_IDLE : SER_DATA;  // glitch, go back
                    end
                end
                SER_DATA: begin
                    if (cnt == FULL_BIT) begin
                        cnt     <= '0;
                        bit_idx <= bit_idx + 1'b1;
                        if (bit_idx == 3'd7) begin
                            state <= SER_STOP;
                        end
                    end
                end
                SER_STOP: begin
                    if (cnt == FULL_BIT) begin  // half a bit into stop
                        byte_valid_o <= rx_s;   // framing error drops the byte
                        state        <= SER_IDLE;
                    end
                end
                default: state <= SER_IDLE;
            endcase
        end
    end

    // lsb arrives first, shift in from the top
    always_ff @(posedge clk_i) begin
        if (sample) begin
            shreg <= {rx_s, shreg[7:1]};
        end
    end

endmodule

/* verilog/rx_fifo.sv */
`timescale 1ns/100ps

module rx_fifo import lsu_bridge_pkg::*; #(
    parameter int FIFO_DEPTH = 4  // power of two
) (
    input  logic  clk_i,
    input  logic  rst_i,
    input  logic  byte_valid_i,
    input  byte_t byte_i,
    uart_regs_if.fifo uart
);
    localparam int PW = $clog2(FIFO_DEPTH);

    byte_t         mem [FIFO_DEPTH];
    logic [PW-1:0] wptr;
    logic [PW-1:0] rptr;
    logic [PW:0]   count;  // needs one extra bit for full
    logic          full;
    logic          push;
    logic          pop;

    assign full  = (count == (PW + 1)'(FIFO_DEPTH));
    assign pop   = uart.rx_pop & uart.rx_avail;
    assign push  = byte_valid_i & (~full | pop);  // drop newest when full

    assign uart.rx_avail = (count != '0);
    assign uart.rx_data  = mem[rptr];  // head is always visible

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            wptr  <= '0;
            rptr  <= '0;
            count <= '0;
        end else begin
            if (push) begin
                wptr <= wptr + 1'b1;  // wraps, depth is 2^PW
            end
            if (pop) begin
                rptr <= rptr + 1'b1;
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;  // none, or both at once
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        if (push) begin
            mem[wptr] <= byte_i;
        end
    end

    a_count_bound: assert property (@(posedge clk_i) disable iff (rst_i)
        count <= (PW + 1)'(FIFO_DEPTH));

endmodule

/* verilog/serial_tx.sv */
`timescale 1ns/100ps

module serial_tx import lsu_bridge_pkg::*; #(
    parameter int CLKS_PER_BIT = 16
) (
    input  logic clk_i,
    input  logic rst_i,
    uart_regs_if.tx uart,
    output logic txd_o
);
    localparam int CW = $clog2(CLKS_PER_BIT);
    localparam logic [CW-1:0] FULL_BIT = CW'(CLKS_PER_BIT - 1);

    serial_state_e state;
    logic [CW-1:0] cnt;
    logic [2:0]    bit_idx;
    byte_t         shreg;
    logic          txd_q;  // registered line, no glitches
    logic          bit_end;

    assign bit_end      = (cnt == FULL_BIT);
    assign uart.tx_busy = (state != SER_IDLE);  // rises the cycle after tx_start
    assign txd_o        = txd_q;

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            state   <= SER_IDLE;
            cnt     <= '0;
            bit_idx <= '0;
            txd_q   <= 1'b1;  // mark
        end else begin
            cnt <= cnt + 1'b1;
            case (state)
                SER_IDLE: begin
                    cnt <= '0;
                    if (uart.tx_start) begin
                        state <= SER_START;
                        txd_q <= 1'b0;  // start bit
                    end
                end
                SER_START: begin
                    if (bit_end) begin
                        cnt     <= '0;
                        bit_idx <= '0;
                        state   <= SER_DATA;
                        txd_q   <= shreg[0];  // lsb first
                    end
                end
                SER_DATA: begin
                    if (bit_end) begin
                        cnt     <= '0;
                        bit_idx <= bit_idx + 1'b1;
                        if (bit_idx == 3'd7) begin
                            state <= SER_STOP;
                            txd_q <= 1'b1;  // stop bit
                        end else begin
                            txd_q <= shreg[1];  // next bit before the shift
                        end
                    end
                end
                SER_STOP: begin
                    if (bit_end) begin
                        cnt   <= '0;
                        state <= SER_IDLE;
                    end
                end
                default: state <= SER_IDLE;
            endcase
        end
    end

    // payload, loaded at start and shifted per data bit
    always_ff @(posedge clk_i) begin
        if (state == SER_IDLE && uart.tx_start) begin
            shreg <= uart.tx_data;
        end else if (state == SER_DATA && bit_end) begin
            shreg <= shreg >> 1;
        end
    end

    a_idle_mark: assert property (@(posedge clk_i) disable iff (rst_i)
        !uart.tx_busy |-> txd_o);

endmodule

/* verilog/data_ram.sv */
`timescale 1ns/100ps

module data_ram import lsu_bridge_pkg::*; #(
    parameter int RAM_WORDS = 256  // power of two
) (
    input logic clk_i,
    ram_port_if.mem ram
);
    word_t mem [RAM_WORDS];  // contents undefined until written

    always_ff @(posedge clk_i) begin
        if (ram.we) begin
            for (int b = 0; b < 4; b++) begin
                if (ram.be[b]) begin  // merge per lane
                    mem[ram.addr][8*b +: 8] <= ram.wdata[8*b +: 8];
                end
            end
        end
        ram.rdata <= mem[ram.addr];  // old data on a write cycle
    end

endmodule

/* verilog/apb_bridge.sv */
`timescale 1ns/100ps

module apb_bridge import lsu_bridge_pkg::*; #(
    parameter int RAM_WORDS = 256
) (
    input  logic  clk_i,
    input  logic  rst_i,
    input  logic  psel_i,
    input  logic  penable_i,
    input  logic  pwrite_i,
    input  addr_t paddr_i,
    input  word_t pwdata_i,
    input  strb_t pstrb_i,
    output word_t prdata_o,
    output logic  pready_o,
    output logic  pslverr_o,
    ram_port_if.bridge  ram,
    uart_regs_if.bridge uart
);
    localparam int    AW      = $clog2(RAM_WORDS);
    localparam addr_t RAM_END = RAM_BASE + addr_t'(4 * RAM_WORDS);  // exclusive

    bridge_state_e state_q;
    bridge_state_e state_d;
    access_e       acc_q;  // decoded in setup
    logic          setup;
    logic          access;
    word_t         stat_word;

    function automatic access_e decode(addr_t a);
        access_e acc;
        if (a >= RAM_BASE && a < RAM_END) begin
            acc = ACC_RAM;
        end else if (a == UART_DATA_ADDR) begin
            acc = ACC_UART_DATA;
        end else if (a == UART_STAT_ADDR) begin
            acc = ACC_UART_STAT;
        end else begin
            acc = ACC_BAD;  // hole in the map
        end
        return acc;
    endfunction

    assign setup  = psel_i & ~penable_i;
    assign access = psel_i & penable_i;

    always_comb begin
        stat_word                = '0;
        stat_word[STAT_TX_IDLE]  = ~uart.tx_busy;
        stat_word[STAT_RX_AVAIL] = uart.rx_avail;
    end

    // ram sees the request straight off the bus
    assign ram.addr     = paddr_i[AW+1:2];
    assign ram.be       = pstrb_i;
    assign ram.wdata    = pwdata_i;
    assign uart.tx_data = pwdata_i[7:0];

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            state_q <= BR_IDLE;
            acc_q   <= ACC_BAD;
        end else begin
            state_q <= state_d;
            if (setup) begin
                acc_q <= decode(paddr_i);
            end
        end
    end

    always_comb begin
        state_d       = state_q;
        pready_o      = 1'b0;
        pslverr_o     = 1'b0;
        prdata_o      = '0;  // zero unless a read completes cleanly
        ram.we        = 1'b0;
        uart.tx_start = 1'b0;
        uart.rx_pop   = 1'b0;
        case (state_q)
            BR_IDLE: begin
                if (setup) begin
                    state_d = BR_ACCESS;
                end
            end
            BR_ACCESS: begin
                if (access) begin
                    state_d = BR_IDLE;
                    case (acc_q)
                        ACC_RAM: begin
                            if (pwrite_i) begin
                                ram.we   = 1'b1;  // done in one cycle
                                pready_o = 1'b1;
                            end else begin
                                state_d = BR_RAM_WAIT;  // one wait state
                            end
                        end
                        ACC_UART_DATA: begin
                            if (pwrite_i && uart.tx_busy) begin
                                state_d = BR_TX_WAIT;  // back-pressure
                            end else if (pwrite_i) begin
                                uart.tx_start = 1'b1;
                                pready_o      = 1'b1;
                            end else if (uart.rx_avail) begin
                                uart.rx_pop = 1'b1;
                                prdata_o    = {24'h0, uart.rx_data};
                                pready_o    = 1'b1;
                            end else begin
                                pready_o  = 1'b1;  // empty fifo
                                pslverr_o = 1'b1;
                            end
                        end
                        ACC_UART_STAT: begin
                            pready_o  = 1'b1;
                            pslverr_o = pwrite_i;  // read only register
                            if (!pwrite_i) begin
                                prdata_o = stat_word;
                            end
                        end
                        default: begin
                            pready_o  = 1'b1;
                            pslverr_o = 1'b1;
                        end
                    endcase
                end
            end
            BR_RAM_WAIT: begin
                pready_o = access;
                prdata_o = ram.rdata;
                state_d  = BR_IDLE;
            end
            BR_TX_WAIT: begin
                if (!uart.tx_busy) begin
                    state_d = BR_ACCESS;  // retry, now completes
                end
            end
            default: state_d = BR_IDLE;
        endcase
    end

    a_tx_start_idle: assert property (@(posedge clk_i) disable iff (rst_i)
        uart.tx_start |-> !uart.tx_busy);
    a_rx_pop_avail: assert property (@(posedge clk_i) disable iff (rst_i)
        uart.rx_pop |-> uart.rx_avail);

endmodule

/* verilog/lsu_bridge_top.sv */
`timescale 1ns/100ps

module lsu_bridge_top import lsu_bridge_pkg::*; #(
    parameter int CLKS_PER_BIT = 16,
    parameter int FIFO_DEPTH   = 4,
    parameter int RAM_WORDS    = 256
) (
    input  logic  clk_i,
    input  logic  rst_i,
    input  logic  psel_i,
    input  logic  penable_i,
    input  logic  pwrite_i,
    input  addr_t paddr_i,
    input  word_t pwdata_i,
    input  strb_t pstrb_i,
    output word_t prdata_o,
    output logic  pready_o,
    output logic  pslverr_o,
    input  logic  rxd_i,
    output logic  txd_o
);
    logic  rx_valid;  // receiver to fifo
    byte_t rx_byte;

    ram_port_if #(.AW($clog2(RAM_WORDS))) ram_bus ();
    uart_regs_if uart_bus ();

    apb_bridge #(.RAM_WORDS(RAM_WORDS)) u_bridge (
        .clk_i     (clk_i),
        .rst_i     (rst_i),
        .psel_i    (psel_i),
        .penable_i (penable_i),
        .pwrite_i  (pwrite_i),
        .paddr_i   (paddr_i),
        .pwdata_i  (pwdata_i),
        .pstrb_i   (pstrb_i),
        .prdata_o  (prdata_o),
        .pready_o  (pready_o),
        .pslverr_o (pslverr_o),
        .ram       (ram_bus.bridge),
        .uart      (uart_bus.bridge)
    );

    data_ram #(.RAM_WORDS(RAM_WORDS)) u_ram (
        .clk_i (clk_i),
        .ram   (ram_bus.mem)
    );

    serial_rx #(.CLKS_PER_BIT(CLKS_PER_BIT)) u_rx (
        .clk_i        (clk_i),
        .rst_i        (rst_i),
        .rxd_i        (rxd_i),
        .byte_valid_o (rx_valid),
        .byte_o       (rx_byte)
    );

    rx_fifo #(.FIFO_DEPTH(FIFO_DEPTH)) u_fifo (
        .clk_i        (clk_i),
        .rst_i        (rst_i),
        .byte_valid_i (rx_valid),
        .byte_i       (rx_byte),
        .uart         (uart_bus.fifo)
    );

    serial_tx #(.CLKS_PER_BIT(CLKS_PER_BIT)) u_tx (
        .clk_i (clk_i),
        .rst_i (rst_i),
        .uart  (uart_bus.tx),
        .txd_o (txd_o)
    );

endmodule

/* tb/tb_agents.svh */
`ifndef TB_AGENTS_SVH
`define TB_AGENTS_SVH

// fibonacci lfsr, taps 16 14 13 11
function automatic logic lfsr_step();
    logic fb;
    fb = lfsr_state[15] ^ lfsr_state[13] ^ lfsr_state[12] ^ lfsr_state[10];
    lfsr_state = {lfsr_state[14:0], fb};
    return fb;
endfunction

// one lfsr step per bit taken, msb first
function automatic word_t random_bits(input int n);
    word_t v;
    v = '0;
    for (int i = 0; i < n; i++) begin
        v = {v[30:0], lfsr_step()};
    end
    return v;
endfunction

// one apb transfer, setup then access until pready_o
task automatic bus_access(
    input  logic  wr,
    input  addr_t addr,
    input  word_t wdata,
    input  strb_t strb,
    output word_t rdata,
    output logic  err,
    output int    cycles
);
    logic done;
    done = 1'b0;
    @(negedge clk_i);
    psel_i    = 1'b1;  // setup phase
    penable_i = 1'b0;
    pwrite_i  = wr;
    paddr_i   = addr;
    pwdata_i  = wdata;
    pstrb_i   = strb;
    @(negedge clk_i);
    penable_i = 1'b1;
    cycles    = 1;
    while (!done) begin
        #1;  // settled, well clear of either edge
        if (pready_o) begin
            rdata = prdata_o;
            err   = pslverr_o;
            done  = 1'b1;
            @(posedge clk_i);  // transfer completes on this edge
        end else begin
            @(negedge clk_i);
            cycles++;
            if (cycles > STALL_LIMIT) begin
                errors++;
                $display("transfer to address %h never completed", addr);
                rdata = '0;
                err   = 1'b1;
                done  = 1'b1;
            end
        end
    end
    @(negedge clk_i);
    psel_i    = 1'b0;
    penable_i = 1'b0;
    pwrite_i  = 1'b0;
endtask

// 8n1 frame on rxd_i, also logged in the rx model
task automatic send_rx_frame(input byte_t b);
    logic [9:0] frame;
    frame = {1'b1, b, 1'b0};  // stop, data, start
    rx_q.push_back(b);
    for (int k = 0; k < 10; k++) begin
        @(negedge clk_i);
        rxd_i = frame[k];
        repeat (CLKS_PER_BIT - 1) @(negedge clk_i);
    end
endtask

`endif

/* tb/lsu_bridge_tb.sv */
`timescale 1ns/100ps

module lsu_bridge_tb import lsu_bridge_pkg::*; ();

    localparam int CLKS_PER_BIT = 8;
    localparam int FIFO_DEPTH   = 4;
    localparam int RAM_WORDS    = 256;
    localparam int AW           = $clog2(RAM_WORDS);
    localparam int RAM_WRITES   = 40;
    localparam int TX_BYTES     = 6;
    localparam int RX_BYTES     = 3;
    localparam int FLOOD_BYTES  = 6;  // more than the fifo holds
    localparam int N_FRAMES     = TX_BYTES + RX_BYTES + FLOOD_BYTES;
    localparam int N_ACCESSES   = 2 * RAM_WRITES + TX_BYTES + 2 * RX_BYTES + FIFO_DEPTH + 16;
    localparam int STALL_LIMIT  = 12 * CLKS_PER_BIT;  // longer than one frame
    localparam int WATCHDOG_CYCLES = 2 * (N_FRAMES * 10 * CLKS_PER_BIT + N_ACCESSES * 10) + 200;

    logic  clk_i = 1'b0;
    logic  rst_i;
    logic  psel_i;
    logic  penable_i;
    logic  pwrite_i;
    addr_t paddr_i;
    word_t pwdata_i;
    strb_t pstrb_i;
    word_t prdata_o;
    logic  pready_o;
    logic  pslverr_o;
    logic  rxd_i;
    logic  txd_o;

    int          errors = 0;
    int          checks = 0;
    logic [15:0] lfsr_state = 16'd78;
    word_t       ram_model [RAM_WORDS];
    strb_t       lane_valid [RAM_WORDS];  // bytes written so far
    int          written_q [$];           // word indices in write order
    byte_t       tx_q [$];                // bytes written to the uart
    byte_t       rx_q [$];                // bytes sent on rxd_i
    int          tx_seen = 0;

    lsu_bridge_top #(
        .CLKS_PER_BIT (CLKS_PER_BIT),
        .FIFO_DEPTH   (FIFO_DEPTH),
        .RAM_WORDS    (RAM_WORDS)
    ) uut (
        .clk_i     (clk_i),
        .rst_i     (rst_i),
        .psel_i    (psel_i),
        .penable_i (penable_i),
        .pwrite_i  (pwrite_i),
        .paddr_i   (paddr_i),
        .pwdata_i  (pwdata_i),
        .pstrb_i   (pstrb_i),
        .prdata_o  (prdata_o),
        .pready_o  (pready_o),
        .pslverr_o (pslverr_o),
        .rxd_i     (rxd_i),
        .txd_o     (txd_o)
    );

    always #5 clk_i = ~clk_i;  // 100 MHz

    `include "tb_agents.svh"

    task automatic compare_word(input string name, input word_t got, input word_t exp);
        checks++;
        assert (got === exp) else begin
            errors++;
            $display("Error: %s = %h, expected %h at %0t", name, got, exp, $time);
        end
    endtask

    task automatic require(input logic cond, input string msg);
        checks++;
        assert (cond) else begin
            errors++;
            $display("%s at %0t", msg, $time);
        end
    endtask

    function automatic word_t status_word(input logic tx_idle, input logic rx_avail);
        word_t w;
        w                = '0;
        w[STAT_TX_IDLE]  = tx_idle;
        w[STAT_RX_AVAIL] = rx_avail;
        return w;
    endfunction

    function automatic word_t byte_mask(input strb_t s);
        word_t m;
        for (int b = 0; b < 4; b++) begin
            m[8*b +: 8] = {8{s[b]}};
        end
        return m;
    endfunction

    // unmapped or illegal access, must end in pslverr with zero data
    task automatic expect_slverr(input logic wr, input addr_t addr);
        word_t rd;
        logic  err;
        int    cyc;
        bus_access(wr, addr, 32'hDEAD_BEEF, 4'hF, rd, err, cyc);
        compare_word("pslverr_o", word_t'(err), 32'h1);
        compare_word("prdata_o", rd, '0);
    endtask

    // txd_o decoder, sampled mid-bit on falling edges
    initial begin
        byte_t got;
        forever begin
            @(negedge clk_i);
            if (!rst_i && txd_o === 1'b0) begin
                repeat (CLKS_PER_BIT / 2) @(negedge clk_i);
                require(txd_o === 1'b0, "start bit on txd_o ended early");
                for (int k = 0; k < 8; k++) begin
                    repeat (CLKS_PER_BIT) @(negedge clk_i);
                    got[k] = txd_o;  // lsb first
                end
                repeat (CLKS_PER_BIT) @(negedge clk_i);
                require(txd_o === 1'b1, "stop bit on txd_o was low");
                if (tx_q.size() == 0) begin
                    require(1'b0, "frame on txd_o with no byte written");
                end else begin
                    compare_word("txd_o byte", word_t'(got), word_t'(tx_q.pop_front()));
                end
                tx_seen++;
            end
        end
    end

    initial begin
        #(WATCHDOG_CYCLES * 10);
        $display("watchdog expired after %0d cycles, %0d checks, %0d errors",
                 WATCHDOG_CYCLES, checks, errors);
        $display("TEST FAILED");
        $finish;
    end

    initial begin
        word_t rd;
        logic  err;
        int    cyc;
        int    idx;
        word_t data;
        strb_t strb;
        byte_t b;
        for (int i = 0; i < RAM_WORDS; i++) begin
            ram_model[i]  = '0;
            lane_valid[i] = '0;
        end
        rst_i     = 1'b1;
        psel_i    = 1'b0;
        penable_i = 1'b0;
        pwrite_i  = 1'b0;
        paddr_i   = '0;
        pwdata_i  = '0;
        pstrb_i   = '0;
        rxd_i     = 1'b1;  // line idle
        repeat (8) @(negedge clk_i);
        rst_i = 1'b0;

        // reset state
        require(txd_o === 1'b1, "txd_o not idle high after reset");
        bus_access(1'b0, UART_STAT_ADDR, '0, '0, rd, err, cyc);
        compare_word("prdata_o", rd, status_word(1'b1, 1'b0));
        compare_word("pslverr_o", word_t'(err), '0);

        // random ram writes, merged into the model lane by lane
        for (int i = 0; i < RAM_WRITES; i++) begin
            idx  = int'(random_bits(AW));
            data = random_bits(32);
            strb = strb_t'(random_bits(4));
            bus_access(1'b1, RAM_BASE + addr_t'(idx * 4), data, strb, rd, err, cyc);
            for (int bl = 0; bl < 4; bl++) begin
                if (strb[bl]) begin
                    ram_model[idx][8*bl +: 8] = data[8*bl +: 8];
                end
            end
            lane_valid[idx] |= strb;
            written_q.push_back(idx);
            compare_word("pslverr_o", word_t'(err), '0);
            compare_word("write access cycles", word_t'(cyc), 32'd1);
        end
        foreach (written_q[i]) begin
            idx = written_q[i];
            bus_access(1'b0, RAM_BASE + addr_t'(idx * 4), '0, '0, rd, err, cyc);
            // never written lanes are unknown in the ram
            compare_word("prdata_o", rd & byte_mask(lane_valid[idx]),
                         ram_model[idx] & byte_mask(lane_valid[idx]));
            compare_word("pslverr_o", word_t'(err), '0);
            compare_word("read access cycles", word_t'(cyc), 32'd2);
        end

        // transmit, back to back
        for (int i = 0; i < TX_BYTES; i++) begin
            b = byte_t'(random_bits(8));
            tx_q.push_back(b);
            bus_access(1'b1, UART_DATA_ADDR, {24'h0, b}, 4'h1, rd, err, cyc);
            compare_word("pslverr_o", word_t'(err), '0);
            if (i == 0) begin
                compare_word("tx write access cycles", word_t'(cyc), 32'd1);
            end else begin
                require(cyc > 1, "data write was not held off while a frame was sent");
            end
        end
        bus_access(1'b0, UART_STAT_ADDR, '0, '0, rd, err, cyc);
        compare_word("prdata_o", rd, status_word(1'b0, 1'b0));  // last frame running
        cyc = 0;
        while (tx_seen < TX_BYTES && cyc < 2 * STALL_LIMIT) begin
            @(negedge clk_i);
            cyc++;
        end
        require(tx_seen == TX_BYTES, "monitor did not see every byte written to the uart");
        repeat (CLKS_PER_BIT) @(negedge clk_i);  // rest of the stop bit
        bus_access(1'b0, UART_STAT_ADDR, '0, '0, rd, err, cyc);
        compare_word("prdata_o", rd, status_word(1'b1, 1'b0));

        // receive, one byte at a time with gaps
        for (int i = 0; i < RX_BYTES; i++) begin
            send_rx_frame(byte_t'(random_bits(8)));
            repeat (2 * CLKS_PER_BIT) @(negedge clk_i);
            bus_access(1'b0, UART_STAT_ADDR, '0, '0, rd, err, cyc);
            compare_word("prdata_o", rd, status_word(1'b1, 1'b1));
            bus_access(1'b0, UART_DATA_ADDR, '0, '0, rd, err, cyc);
            compare_word("prdata_o", rd, {24'h0, rx_q.pop_front()});
            compare_word("pslverr_o", word_t'(err), '0);
        end
        bus_access(1'b0, UART_STAT_ADDR, '0, '0, rd, err, cyc);
        compare_word("prdata_o", rd, status_word(1'b1, 1'b0));

        // overflow, newest bytes get dropped
        for (int i = 0; i < FLOOD_BYTES; i++) begin
            send_rx_frame(byte_t'(random_bits(8)));
        end
        repeat (2 * CLKS_PER_BIT) @(negedge clk_i);
        for (int i = 0; i < FIFO_DEPTH; i++) begin
            bus_access(1'b0, UART_DATA_ADDR, '0, '0, rd, err, cyc);
            compare_word("prdata_o", rd, {24'h0, rx_q.pop_front()});
            compare_word("pslverr_o", word_t'(err), '0);
        end
        expect_slverr(1'b0, UART_DATA_ADDR);  // empty again
        rx_q.delete();

        // unmapped addresses and the read only status register
        expect_slverr(1'b0, RAM_BASE + addr_t'(4 * RAM_WORDS));
        expect_slverr(1'b1, RAM_BASE + addr_t'(4 * RAM_WORDS));  // aliases word 0 if decoded wrong
        expect_slverr(1'b0, RAM_BASE - 32'd4);
        expect_slverr(1'b1, UART_DATA_ADDR - 32'd4);
        expect_slverr(1'b0, UART_STAT_ADDR + 32'd4);
        expect_slverr(1'b0, 32'h0000_0000);
        expect_slverr(1'b1, UART_STAT_ADDR);
        idx = written_q[0];
        bus_access(1'b0, RAM_BASE + addr_t'(idx * 4), '0, '0, rd, err, cyc);
        compare_word("prdata_o", rd & byte_mask(lane_valid[idx]),
                     ram_model[idx] & byte_mask(lane_valid[idx]));
        compare_word("pslverr_o", word_t'(err), '0);

        repeat (4) @(negedge clk_i);
        $display("%0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

/* lsu_bridge_top.f */
+incdir+tb
verilog/lsu_bridge_pkg.sv
verilog/bus_ifs.sv
verilog/serial_rx.sv
verilog/rx_fifo.sv
verilog/serial_tx.sv
verilog/data_ram.sv
verilog/apb_bridge.sv
verilog/lsu_bridge_top.sv
tb/lsu_bridge_tb.sv

/* Bender.yml */
package:
  name: lsu_bridge

sources:
  - files:
      - verilog/lsu_bridge_pkg.sv
      - verilog/bus_ifs.sv
      - verilog/serial_rx.sv
      - verilog/rx_fifo.sv
      - verilog/serial_tx.sv
      - verilog/data_ram.sv
      - verilog/apb_bridge.sv
      - verilog/lsu_bridge_top.sv
  - target: test
    include_dirs:
      - tb
    files:
      - tb/lsu_bridge_tb.sv
